// ==== include/trig_defines.svh ====
// Trigger subsystem sizing.
// Channel count, field widths and the default FIFO depth.

`ifndef TRIG_DEFINES_SVH
`define TRIG_DEFINES_SVH

// channel FPGAs fed by the trigger manager
`define TRIG_NUM_CHAN 5

// field widths
`define TRIG_FILL_W 2
`define TRIG_DELAY_W 4
`define TRIG_WORD_W 64

// words held for the command manager
`define TRIG_FIFO_DEPTH 16

`endif

// ==== rtl/trig_pkg.sv ====
// Trigger subsystem types.
// Field types, the config and channel control structs and the manager state.

`include "trig_defines.svh"

package trig_pkg;

  // one bit per channel FPGA
  typedef logic [`TRIG_NUM_CHAN-1:0] chan_mask_t;
  // muon fill, laser, pedestal
  typedef logic [`TRIG_FILL_W-1:0] fill_type_t;
  // trigger delay in clock cycles
  typedef logic [`TRIG_DELAY_W-1:0] trig_delay_t;
  // trigger number, timestamp or FIFO word
  typedef logic [`TRIG_WORD_W-1:0] trig_word_t;

  // trigger configuration, sampled on acceptance
  typedef struct packed {
    chan_mask_t  chan_en;
    fill_type_t  fill_type;
    trig_delay_t trig_delay;
  } trig_config_t;

  // strobes toward the channel FPGAs
  typedef struct packed {
    logic [`TRIG_NUM_CHAN*`TRIG_FILL_W-1:0] enable;
    chan_mask_t                             trig;
  } acq_ctrl_t;

  // manager FSM states
  typedef enum logic [2:0] {
    IDLE,
    DELAY,
    FILL,
    STORE_NUM,
    STORE_TIME
  } trig_state_t;

endpackage

// ==== rtl/trigger_stamp.sv ====
// Trigger stamp.
// Counts accepted triggers and captures a free-running cycle count
// as the timestamp of each one.

`timescale 1ns/1ps

module trigger_stamp (
  input  logic                 clk,
  input  logic                 reset,

  // TTC channel B resets
  input  logic                 reset_trig_num,
  input  logic                 reset_trig_timestamp,

  // pulse from the manager
  input  logic                 trig_accept,

  output trig_pkg::trig_word_t trig_num,
  output trig_pkg::trig_word_t trig_timestamp
);

  import trig_pkg::*;

  // cycles since the last reset
  trig_word_t timestamp_cnt;

  // trigger counter, first trigger is number 1
  always_ff @(posedge clk) begin
    if (reset || reset_trig_num) begin
      trig_num <= '0;
    end else if (trig_accept) begin
      trig_num <= trig_num + trig_word_t'(1);
    end
  end

  // free-running count and capture on acceptance
  always_ff @(posedge clk) begin
    if (reset || reset_trig_timestamp) begin
      timestamp_cnt  <= '0;
      trig_timestamp <= '0;
    end else begin
      timestamp_cnt <= timestamp_cnt + trig_word_t'(1);
      if (trig_accept) begin
        trig_timestamp <= timestamp_cnt;
      end
    end
  end

  // one accept, one count
  a_num_step: assert property (
    @(posedge clk) disable iff (reset)
    (trig_accept && !reset_trig_num) |=> (trig_num == $past(trig_num) + trig_word_t'(1))
  ) else $error("trigger_stamp: trig_num did not step by one");

endmodule

// ==== rtl/trigger_manager.sv ====
// Trigger manager FSM.
// Delays an accepted trigger, hands it to the enabled channel FPGAs,
// waits for all of them to finish, then pushes the trigger number and
// timestamp into the info FIFO.

`timescale 1ns/1ps
`include "trig_defines.svh"

module trigger_manager (
  input  logic                     clk,
  input  logic                     reset,

  // trigger and its configuration
  input  logic                     trigger,
  input  trig_pkg::trig_config_t   cfg,

  // channel FPGA interface
  input  trig_pkg::chan_mask_t     acq_done,
  output trig_pkg::acq_ctrl_t      acq,

  // stamp interface
  input  trig_pkg::trig_word_t     trig_num,
  input  trig_pkg::trig_word_t     trig_timestamp,
  output logic                     trig_accept,

  // info FIFO write side
  input  logic                     fifo_ready,
  output logic                     fifo_valid,
  output trig_pkg::trig_word_t     fifo_data,

  // status
  output trig_pkg::trig_state_t    state
);

  import trig_pkg::*;

  trig_state_t  next_state;
  trig_config_t cfg_q;
  trig_delay_t  delay_cnt;
  logic         word_done;
  logic         mask_done;

  // a trigger is taken only in IDLE and dropped otherwise
  assign trig_accept = (state == IDLE) && trigger;

  // word leaves the output stage this cycle
  assign word_done = fifo_valid && fifo_ready;

  // every enabled channel reports done
  assign mask_done = (acq_done == cfg_q.chan_en);

  // next state logic
  always_comb begin
    next_state = state;
    unique case (state)
      IDLE: begin
        if (trig_accept) begin
          // zero delay goes straight to the channels
          if (cfg.trig_delay == '0) begin
            next_state = FILL;
          end else begin
            next_state = DELAY;
          end
        end
      end
      DELAY: begin
        // counter was loaded with d-1 and gives d cycles here
        if (delay_cnt == '0) begin
          next_state = FILL;
        end
      end
      FILL: begin
        if (mask_done) begin
          next_state = STORE_NUM;
        end
      end
      STORE_NUM: begin
        if (word_done) begin
          next_state = STORE_TIME;
        end
      end
      STORE_TIME: begin
        if (word_done) begin
          next_state = IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  // channel strobes active only while filling
  always_comb begin
    acq = '0;
    if (state == FILL) begin
      acq.trig   = cfg_q.chan_en;
      // same fill type on every channel pair
      acq.enable = {`TRIG_NUM_CHAN{cfg_q.fill_type}};
    end
  end

  // state register and delay down-counter
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= IDLE;
      delay_cnt <= '0;
    end else begin
      state <= next_state;
      if (trig_accept) begin
        delay_cnt <= cfg.trig_delay - trig_delay_t'(1);
      end else if (state == DELAY) begin
        delay_cnt <= delay_cnt - trig_delay_t'(1);
      end
    end
  end

  // config held for the whole trigger
  always_ff @(posedge clk) begin
    if (trig_accept) begin
      cfg_q <= cfg;
    end
  end

  // registered FIFO output stage loaded from the next state
  always_ff @(posedge clk) begin
    if (reset) begin
      fifo_valid <= 1'b0;
    end else begin
      fifo_valid <= (next_state == STORE_NUM) || (next_state == STORE_TIME);
    end
  end

  // word loaded on entry only and held while the FIFO is full
  always_ff @(posedge clk) begin
    if (next_state != state) begin
      if (next_state == STORE_NUM) begin
        fifo_data <= trig_num;
      end else if (next_state == STORE_TIME) begin
        fifo_data <= trig_timestamp;
      end
    end
  end

  // stalled word must not change under the FIFO
  a_data_held: assert property (
    @(posedge clk) disable iff (reset)
    (fifo_valid && !fifo_ready) |=> (fifo_valid && $stable(fifo_data))
  ) else $error("trigger_manager: fifo word changed while stalled");

endmodule

// ==== rtl/trigger_info_fifo.sv ====
// Trigger info FIFO.
// Synchronous first-word-fall-through buffer of trigger words
// for the command manager.

`timescale 1ns/1ps
`include "trig_defines.svh"

module trigger_info_fifo #(
  parameter int DEPTH = `TRIG_FIFO_DEPTH
) (
  input  logic                 clk,
  input  logic                 reset,

  // write side, from the trigger manager
  input  logic                 wr_valid,
  input  trig_pkg::trig_word_t wr_data,
  output logic                 wr_ready,

  // read side, toward the command manager
  input  logic                 rd_pop,
  output logic                 rd_valid,
  output trig_pkg::trig_word_t rd_data
);

  import trig_pkg::*;

  localparam int AW   = $clog2(DEPTH);
  localparam int CNTW = AW + 1;

  trig_word_t      mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [CNTW-1:0] count;
  logic            push;
  logic            pop;

  // not full and not empty
  assign wr_ready = (count != CNTW'(DEPTH));
  assign rd_valid = (count != '0);

  // pop on an empty FIFO is ignored
  assign push = wr_valid && wr_ready;
  assign pop  = rd_pop && rd_valid;

  // head word drives the output directly
  assign rd_data = mem[rd_ptr];

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // pointers wrap naturally, DEPTH is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + AW'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + AW'(1);
      end
      // push and pop together keep the count
      if (push && !pop) begin
        count <= count + CNTW'(1);
      end else if (pop && !push) begin
        count <= count - CNTW'(1);
      end
    end
  end

  // full FIFO takes nothing until a word is read
  a_no_push_full: assert property (
    @(posedge clk) disable iff (reset)
    (!wr_ready && !rd_pop) |=> (!wr_ready && $stable(wr_ptr))
  ) else $error("trigger_info_fifo: push while full");

  // empty FIFO gives nothing until a word is written
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (reset)
    (!rd_valid && !wr_valid) |=> (!rd_valid && $stable(rd_ptr))
  ) else $error("trigger_info_fifo: pop while empty");

endmodule

// ==== rtl/trigger_subsystem.sv ====
// Trigger handling subsystem.
// Stamps incoming triggers, sequences the channel FPGAs and queues
// trigger number and timestamp for the command manager.

`timescale 1ns/1ps

module trigger_subsystem (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  reset_trig_num,
  input  logic                  reset_trig_timestamp,

  // trigger and configuration
  input  logic                  trigger,
  input  trig_pkg::trig_config_t cfg,

  // channel FPGA interface
  input  trig_pkg::chan_mask_t  acq_done,
  output trig_pkg::acq_ctrl_t   acq,

  // info FIFO read side
  input  logic                  info_read,
  output logic                  info_valid,
  output trig_pkg::trig_word_t  info_data,

  // status
  output trig_pkg::trig_state_t state,
  output trig_pkg::trig_word_t  trig_num,
  output trig_pkg::trig_word_t  trig_timestamp
);

  import trig_pkg::*;

  // manager to stamp
  logic       trig_accept;

  // manager to FIFO
  logic       fifo_valid;
  logic       fifo_ready;
  trig_word_t fifo_data;

  trigger_stamp u_stamp (
    .clk                  (clk),
    .reset                (reset),
    .reset_trig_num       (reset_trig_num),
    .reset_trig_timestamp (reset_trig_timestamp),
    .trig_accept          (trig_accept),
    .trig_num             (trig_num),
    .trig_timestamp       (trig_timestamp)
  );

  trigger_manager u_manager (
    .clk            (clk),
    .reset          (reset),
    .trigger        (trigger),
    .cfg            (cfg),
    .acq_done       (acq_done),
    .acq            (acq),
    .trig_num       (trig_num),
    .trig_timestamp (trig_timestamp),
    .trig_accept    (trig_accept),
    .fifo_ready     (fifo_ready),
    .fifo_valid     (fifo_valid),
    .fifo_data      (fifo_data),
    .state          (state)
  );

  // default depth
  trigger_info_fifo u_info_fifo (
    .clk      (clk),
    .reset    (reset),
    .wr_valid (fifo_valid),
    .wr_data  (fifo_data),
    .wr_ready (fifo_ready),
    .rd_pop   (info_read),
    .rd_valid (info_valid),
    .rd_data  (info_data)
  );

endmodule

// ==== testbench/tb_trigger_subsystem.sv ====
// Testbench for the trigger handling subsystem.
// Random triggers and reads, emulated channel FPGAs and a reference
// model of trigger numbers, timestamps and FIFO contents.

`timescale 1ns/1ps
`include "trig_defines.svh"

module tb_trigger_subsystem;

  import trig_pkg::*;

  localparam int NUM_TRIGGERS = 200;
  localparam int RESET_CYCLES = 16;
  localparam int CLK_PERIOD   = 40;
  localparam int TIMEOUT_NS   = (NUM_TRIGGERS * 64 + RESET_CYCLES) * CLK_PERIOD;

  logic         clk;
  logic         reset;
  logic         reset_trig_num;
  logic         reset_trig_timestamp;
  logic         trigger;
  trig_config_t cfg;
  chan_mask_t   acq_done = '0;
  logic         info_read;
  acq_ctrl_t    acq;
  logic         info_valid;
  trig_word_t   info_data;
  trig_state_t  state;
  trig_word_t   trig_num;
  trig_word_t   trig_timestamp;

  // reference model
  trig_word_t   exp_words[$];
  trig_word_t   model_num;
  trig_word_t   cycle_cnt;
  trig_config_t cfg_lat;
  logic         accept_pend;
  int           accepted;
  int           since_accept;
  // 0 none, 1 waiting for FILL, 2 in FILL
  int           phase;
  logic         prev_valid;
  logic         prev_pop;
  int           hold_cycles;
  logic [31:0]  rnd;

  // channel FPGA emulation
  logic         trig_seen;
  chan_mask_t   done_next;
  int           wait_cnt [`TRIG_NUM_CHAN];

  trigger_subsystem DUT (
    .clk                  (clk),
    .reset                (reset),
    .reset_trig_num       (reset_trig_num),
    .reset_trig_timestamp (reset_trig_timestamp),
    .trigger              (trigger),
    .cfg                  (cfg),
    .acq_done             (acq_done),
    .acq                  (acq),
    .info_read            (info_read),
    .info_valid           (info_valid),
    .info_data            (info_data),
    .state                (state),
    .trig_num             (trig_num),
    .trig_timestamp       (trig_timestamp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within its cycle budget");
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

  task automatic fail_on_mismatch(input string test, input trig_word_t expected,
                                  input trig_word_t actual);
    $display("ERROR %s expected %0h actual %0h", test, expected, actual);
    $display("Simulation finished: FAIL");
    $fatal(1, "mismatch in %s", test);
  endtask

  task automatic compare_word(input string test, input trig_word_t expected,
                              input trig_word_t actual);
    assert (expected === actual) else fail_on_mismatch(test, expected, actual);
  endtask

  task automatic expect_true(input string what, input logic cond);
    assert (cond) else begin
      $display("ERROR %s", what);
      $display("Simulation finished: FAIL");
      $fatal(1, "%s", what);
    end
  endtask

  // channels answer 0 to 7 cycles after acq.trig rises
  always @(negedge clk) begin
    if (reset || acq.trig == '0) begin
      trig_seen = 1'b0;
      done_next = '0;
    end else begin
      if (!trig_seen) begin
        trig_seen = 1'b1;
        for (int i = 0; i < `TRIG_NUM_CHAN; i++) begin
          wait_cnt[i] = int'($urandom_range(7, 0));
        end
      end
      for (int i = 0; i < `TRIG_NUM_CHAN; i++) begin
        if (acq.trig[i] && wait_cnt[i] == 0) begin
          done_next[i] = 1'b1;
        end else if (acq.trig[i]) begin
          wait_cnt[i]--;
        end
      end
    end
    acq_done <= done_next;
  end

  // edge just passed, inputs still hold the values it sampled
  task automatic update_model();
    if (accept_pend) begin
      model_num = model_num + 64'd1;
      compare_word("timestamp capture", cycle_cnt, trig_timestamp);
      exp_words.push_back(model_num);
      exp_words.push_back(cycle_cnt);
      cfg_lat      = cfg;
      since_accept = 0;
      phase        = 1;
    end else begin
      since_accept++;
    end
    if (reset_trig_num) begin
      model_num = '0;
    end
    if (reset_trig_timestamp) begin
      cycle_cnt = '0;
    end else begin
      cycle_cnt = cycle_cnt + 64'd1;
    end
  endtask

  task automatic verify_outputs();
    compare_word("trigger number", model_num, trig_num);
    if (phase == 2) begin
      // acq_done still shows the value of the last edge
      if (acq_done == cfg_lat.chan_en) begin
        compare_word("fill exit", trig_word_t'(STORE_NUM), trig_word_t'(state));
        phase = 0;
      end else begin
        compare_word("fill hold", trig_word_t'(FILL), trig_word_t'(state));
      end
    end else if (phase == 1) begin
      // FILL in the (d+1)th cycle after the accepting edge
      if (since_accept < int'(cfg_lat.trig_delay)) begin
        compare_word("delay", trig_word_t'(DELAY), trig_word_t'(state));
      end else begin
        compare_word("delay end", trig_word_t'(FILL), trig_word_t'(state));
        phase = 2;
      end
    end else begin
      expect_true("manager in DELAY or FILL without an accepted trigger",
                  state != DELAY && state != FILL);
    end
    if (state == FILL) begin
      compare_word("channel mask", trig_word_t'(cfg_lat.chan_en), trig_word_t'(acq.trig));
      for (int i = 0; i < `TRIG_NUM_CHAN; i++) begin
        compare_word("fill type", trig_word_t'(cfg_lat.fill_type),
                     trig_word_t'(acq.enable[i*`TRIG_FILL_W +: `TRIG_FILL_W]));
      end
    end else begin
      compare_word("strobes outside fill", '0, trig_word_t'(acq));
    end
    if (prev_valid && !prev_pop) begin
      expect_true("info_valid dropped without a read", info_valid);
    end
    if (info_valid) begin
      expect_true("FIFO shows a word the model does not expect", exp_words.size() != 0);
    end
  endtask

  task automatic drive_inputs();
    rnd                  = $urandom;
    cfg                  = trig_config_t'(rnd[10:0]);
    trigger              = 1'b0;
    reset_trig_num       = 1'b0;
    reset_trig_timestamp = 1'b0;
    if (accepted < NUM_TRIGGERS) begin
      if (state == IDLE) begin
        if (rnd[15:12] < 4'd3) begin
          trigger = 1'b1;
        end else if (rnd[21:16] == 6'd0) begin
          reset_trig_num = 1'b1;
        end else if (rnd[21:16] == 6'd1) begin
          reset_trig_timestamp = 1'b1;
        end
      end else if (rnd[15:12] == 4'd0) begin
        // busy manager drops this one
        trigger = 1'b1;
      end
    end
    accept_pend = trigger && (state == IDLE);
    if (accept_pend) begin
      accepted++;
    end
    if (hold_cycles > 0) begin
      hold_cycles--;
      info_read = 1'b0;
    end else if (accepted < NUM_TRIGGERS && rnd[31:23] == 9'd0) begin
      // long enough to fill the FIFO and stall the manager
      hold_cycles = int'($urandom_range(300, 150));
      info_read   = 1'b0;
    end else begin
      info_read = (accepted >= NUM_TRIGGERS) || rnd[11];
    end
    if (info_read && info_valid) begin
      compare_word("info word", exp_words[0], info_data);
      void'(exp_words.pop_front());
    end
    prev_pop   = info_read && info_valid;
    prev_valid = info_valid;
  endtask

  initial begin
    // seed the generator once
    rnd                  = $urandom(32'h388cdee6);
    reset                = 1'b1;
    reset_trig_num       = 1'b0;
    reset_trig_timestamp = 1'b0;
    trigger              = 1'b0;
    cfg                  = '0;
    info_read            = 1'b0;
    model_num            = '0;
    cycle_cnt            = '0;
    cfg_lat              = '0;
    accept_pend          = 1'b0;
    accepted             = 0;
    since_accept         = 0;
    phase                = 0;
    prev_valid           = 1'b0;
    prev_pop             = 1'b0;
    hold_cycles          = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    while (accepted < NUM_TRIGGERS || accept_pend || state != IDLE ||
           exp_words.size() != 0) begin
      @(negedge clk);
      update_model();
      verify_outputs();
      drive_inputs();
    end
    // last pop lands on the next edge
    @(negedge clk);
    info_read = 1'b0;
    @(negedge clk);
    if (!info_valid && exp_words.size() == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("ERROR FIFO still holds words after the last expected one was read");
      $display("Simulation finished: FAIL");
      $fatal(1, "words left in the FIFO");
    end
  end

endmodule

// ==== trigger_subsystem.f ====
+incdir+include
rtl/trig_pkg.sv
rtl/trigger_stamp.sv
rtl/trigger_manager.sv
rtl/trigger_info_fifo.sv
rtl/trigger_subsystem.sv
testbench/tb_trigger_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the trigger subsystem testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f trigger_subsystem.f --top-module tb_trigger_subsystem \
  -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
echo "pass message not found"
exit 1
